/* src.f */
source/burst_io_pkg.sv
source/resp_data_pack.sv
source/burst_to_axil.sv
source/axil_scratchpad.sv
source/burst_io_top.sv
tests/tb_burst_io.sv

/* Bender.yml */
package:
  name: burst_io

sources:
  - files:
      - source/burst_io_pkg.sv
      - source/resp_data_pack.sv
      - source/burst_to_axil.sv
      - source/axil_scratchpad.sv
      - source/burst_io_top.sv
  - target: test
    files:
      - tests/tb_burst_io.sv

/* tests/tb_burst_io.sv */
// tb_burst_io
// Random-stimulus testbench for the burst I/O bridge with its scratchpad.
// A byte-array model predicts read data, response headers are checked
// against the command, and every handshake wait is bounded.

`timescale 1ns/1ps
`default_nettype none

module tb_burst_io;

  localparam int timeout_cycles = 1000;
  localparam int model_bytes    = burst_io_pkg::scratch_words * 4;
  localparam int random_cmds    = 400;

  logic                                   clk_i;
  logic                                   reset_i;
  logic                                   cmd_header_v_i;
  logic                                   cmd_header_ready_o;
  burst_io_pkg::mem_msg_e                 cmd_type_i;
  burst_io_pkg::mem_size_e                cmd_size_i;
  logic [burst_io_pkg::paddr_width-1:0]   cmd_addr_i;
  logic                                   cmd_has_data_i;
  logic                                   cmd_data_v_i;
  logic                                   cmd_data_ready_o;
  logic [burst_io_pkg::io_data_width-1:0] cmd_data_i;
  logic                                   cmd_last_i;
  logic                                   resp_header_v_o;
  logic                                   resp_header_ready_i;
  burst_io_pkg::mem_msg_e                 resp_type_o;
  burst_io_pkg::mem_size_e                resp_size_o;
  logic [burst_io_pkg::paddr_width-1:0]   resp_addr_o;
  logic                                   resp_has_data_o;
  logic                                   resp_data_v_o;
  logic                                   resp_data_ready_i;
  logic [burst_io_pkg::io_data_width-1:0] resp_data_o;
  logic                                   resp_last_o;

  // reference copy of the scratchpad with one entry per byte
  logic [7:0] model_mem [model_bytes];
  integer     seed;

  burst_io_top dut_i (.*);

  always #10 clk_i = ~clk_i;

  task automatic fail_now();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name,
                            input logic [burst_io_pkg::io_data_width-1:0] exp,
                            input logic [burst_io_pkg::io_data_width-1:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_type(input string name, input burst_io_pkg::mem_msg_e exp,
                            input burst_io_pkg::mem_msg_e act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_size(input string name, input burst_io_pkg::mem_size_e exp,
                            input burst_io_pkg::mem_size_e act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_addr(input string name,
                            input logic [burst_io_pkg::paddr_width-1:0] exp,
                            input logic [burst_io_pkg::paddr_width-1:0] act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      fail_now();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s never completed its handshake within %0d cycles", what, timeout_cycles);
    fail_now();
  endtask

  // written bytes repeated over all eight lanes
  function automatic logic [63:0] replicate_bytes(input logic [31:0] val, input int n);
    logic [63:0] r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = val[8*(i % n) +: 8];
    end
    return r;
  endfunction

  function automatic logic [63:0] expected_read(input logic [31:0] addr, input int n);
    logic [63:0] r;
    int          base;
    base = addr[9:0];
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = model_mem[base + (i % n)];
    end
    return r;
  endfunction

  task automatic model_write(input logic [31:0] addr, input int n, input logic [31:0] val);
    int base;
    base = addr[9:0];
    for (int j = 0; j < n; j++) begin
      model_mem[base + j] = val[8*j +: 8];
    end
  endtask

  task automatic send_header(input string name, input burst_io_pkg::mem_msg_e typ,
                             input burst_io_pkg::mem_size_e size,
                             input logic [31:0] addr, input logic is_write);
    int   cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < timeout_cycles) begin
      @(negedge clk_i);
      resp_header_ready_i = 1'b0;
      resp_data_ready_i   = 1'b0;
      cmd_header_v_i      = 1'b1;
      cmd_type_i          = typ;
      cmd_size_i          = size;
      cmd_addr_i          = addr;
      cmd_has_data_i      = is_write;
      #1;
      done = cmd_header_ready_o;
      cnt++;
    end
    if (!done) report_timeout({name, " command header"});
  endtask

  task automatic send_data(input string name, input logic [63:0] data, input int gap);
    int   cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    // late data beat
    repeat (gap) begin
      @(negedge clk_i);
      cmd_header_v_i = 1'b0;
      #1;
      check_flag({name, " header ready while busy"}, 1'b0, cmd_header_ready_o);
    end
    while (!done && cnt < timeout_cycles) begin
      @(negedge clk_i);
      cmd_header_v_i = 1'b0;
      cmd_data_v_i   = 1'b1;
      cmd_data_i     = data;
      cmd_last_i     = 1'b1;
      #1;
      check_flag({name, " header ready while busy"}, 1'b0, cmd_header_ready_o);
      check_flag({name, " response before data"}, 1'b0, resp_header_v_o | resp_data_v_o);
      done = cmd_data_ready_o;
      cnt++;
    end
    if (!done) report_timeout({name, " command data"});
  endtask

  task automatic wait_resp_header(input string name, input int busy);
    int   cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < timeout_cycles) begin
      @(negedge clk_i);
      cmd_header_v_i      = 1'b0;
      cmd_data_v_i        = 1'b0;
      resp_header_ready_i = ($random(seed) & 3) >= busy;
      #1;
      check_flag({name, " header ready while busy"}, 1'b0, cmd_header_ready_o);
      check_flag({name, " data before header"}, 1'b0, resp_data_v_o);
      if (resp_header_v_o) check_flag({name, " header last"}, 1'b1, resp_last_o);
      done = resp_header_v_o & resp_header_ready_i;
      cnt++;
    end
    if (!done) report_timeout({name, " response header"});
  endtask

  task automatic wait_resp_data(input string name, input int busy, output logic [63:0] act);
    int   cnt;
    logic done;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < timeout_cycles) begin
      @(negedge clk_i);
      resp_data_ready_i = ($random(seed) & 3) >= busy;
      #1;
      check_flag({name, " header ready while busy"}, 1'b0, cmd_header_ready_o);
      check_flag({name, " second header"}, 1'b0, resp_header_v_o);
      if (resp_data_v_o) check_flag({name, " data last"}, 1'b1, resp_last_o);
      done = resp_data_v_o & resp_data_ready_i;
      cnt++;
    end
    act = resp_data_o;
    if (!done) report_timeout({name, " response data"});
  endtask

  // one full command with read data returned for reads
  task automatic run_cmd(input string name, input burst_io_pkg::mem_msg_e typ,
                         input burst_io_pkg::mem_size_e size, input logic [31:0] addr,
                         input logic [63:0] wdata, output logic [63:0] rdata);
    logic is_write;
    int   gap;
    int   hdr_busy;
    int   data_busy;
    is_write  = (typ == burst_io_pkg::e_mem_wr) || (typ == burst_io_pkg::e_mem_uc_wr);
    gap       = $random(seed) & 3;
    hdr_busy  = $random(seed) & 3;
    data_busy = $random(seed) & 3;
    rdata     = '0;
    send_header(name, typ, size, addr, is_write);
    if (is_write) send_data(name, wdata, gap);
    wait_resp_header(name, hdr_busy);
    check_type({name, " resp type"}, typ, resp_type_o);
    check_size({name, " resp size"}, size, resp_size_o);
    check_addr({name, " resp addr"}, addr, resp_addr_o);
    check_flag({name, " resp has_data"}, ~is_write, resp_has_data_o);
    if (!is_write) wait_resp_data(name, data_busy, rdata);
  endtask

  initial begin
    logic [63:0]             rdata;
    logic [31:0]             addr;
    logic [31:0]             val;
    burst_io_pkg::mem_size_e size;
    burst_io_pkg::mem_msg_e  typ;
    int                      n;
    seed                = 32'hc7b5;
    clk_i               = 1'b0;
    reset_i             = 1'b1;
    cmd_header_v_i      = 1'b0;
    cmd_type_i          = burst_io_pkg::e_mem_rd;
    cmd_size_i          = burst_io_pkg::e_size_1;
    cmd_addr_i          = '0;
    cmd_has_data_i      = 1'b0;
    cmd_data_v_i        = 1'b0;
    cmd_data_i          = '0;
    cmd_last_i          = 1'b0;
    resp_header_ready_i = 1'b0;
    resp_data_ready_i   = 1'b0;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    check_flag("reset header ready", 1'b1, cmd_header_ready_o);
    check_flag("reset data ready", 1'b0, cmd_data_ready_o);
    check_flag("reset resp valids", 1'b0, resp_header_v_o | resp_data_v_o);

    // fill every word and read it back
    for (int w = 0; w < burst_io_pkg::scratch_words; w++) begin
      addr = w * 4;
      val  = $random(seed);
      typ  = ($random(seed) & 1) ? burst_io_pkg::e_mem_wr : burst_io_pkg::e_mem_uc_wr;
      run_cmd($sformatf("fill write %0d", w), typ, burst_io_pkg::e_size_4, addr,
              replicate_bytes(val, 4), rdata);
      model_write(addr, 4, val);
    end
    for (int w = 0; w < burst_io_pkg::scratch_words; w++) begin
      addr = w * 4;
      run_cmd($sformatf("fill read %0d", w), burst_io_pkg::e_mem_uc_rd,
              burst_io_pkg::e_size_4, addr, '0, rdata);
      check_data($sformatf("fill read %0d data", w), expected_read(addr, 4), rdata);
    end

    // mixed sub-word traffic where upper address bits wrap
    for (int k = 0; k < random_cmds; k++) begin
      addr = $random(seed);
      if ($random(seed) & 1) begin
        size = burst_io_pkg::mem_size_e'($random(seed) & 1);
        n    = 1 << size;
        addr = addr & ~32'(n - 1);
        val  = $random(seed);
        typ  = ($random(seed) & 1) ? burst_io_pkg::e_mem_wr : burst_io_pkg::e_mem_uc_wr;
        run_cmd($sformatf("random write %0d", k), typ, size, addr,
                replicate_bytes(val, n), rdata);
        model_write(addr, n, val);
      end else begin
        size = burst_io_pkg::mem_size_e'(($random(seed) & 32'h7fffffff) % 3);
        n    = 1 << size;
        addr = addr & ~32'(n - 1);
        typ  = ($random(seed) & 1) ? burst_io_pkg::e_mem_rd : burst_io_pkg::e_mem_uc_rd;
        run_cmd($sformatf("random read %0d", k), typ, size, addr, '0, rdata);
        check_data($sformatf("random read %0d data", k), expected_read(addr, n), rdata);
      end
    end

    // full-word sweep after the sub-word writes
    for (int w = 0; w < burst_io_pkg::scratch_words; w++) begin
      addr = w * 4;
      run_cmd($sformatf("final read %0d", w), burst_io_pkg::e_mem_rd,
              burst_io_pkg::e_size_4, addr, '0, rdata);
      check_data($sformatf("final read %0d data", w), expected_read(addr, 4), rdata);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* source/burst_io_top.sv */
// burst_io_top
// Burst I/O bridge joined to an AXI4-Lite scratchpad, so only the
// burst command and response ports face outward.

`timescale 1ns/1ps
`default_nettype none

module burst_io_top (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic                                    cmd_header_v_i,
  output logic                                    cmd_header_ready_o,
  input  burst_io_pkg::mem_msg_e                  cmd_type_i,
  input  burst_io_pkg::mem_size_e                 cmd_size_i,
  input  logic [burst_io_pkg::paddr_width-1:0]    cmd_addr_i,
  input  logic                                    cmd_has_data_i,
  input  logic                                    cmd_data_v_i,
  output logic                                    cmd_data_ready_o,
  input  logic [burst_io_pkg::io_data_width-1:0]  cmd_data_i,
  input  logic                                    cmd_last_i,

  output logic                                    resp_header_v_o,
  input  logic                                    resp_header_ready_i,
  output burst_io_pkg::mem_msg_e                  resp_type_o,
  output burst_io_pkg::mem_size_e                 resp_size_o,
  output logic [burst_io_pkg::paddr_width-1:0]    resp_addr_o,
  output logic                                    resp_has_data_o,
  output logic                                    resp_data_v_o,
  input  logic                                    resp_data_ready_i,
  output logic [burst_io_pkg::io_data_width-1:0]  resp_data_o,
  output logic                                    resp_last_o
);

  // AXI4-Lite link, named after the bridge ports
  logic [burst_io_pkg::axil_addr_width-1:0] m_axil_awaddr_o;
  burst_io_pkg::axi_prot_e                  m_axil_awprot_o;
  logic                                     m_axil_awvalid_o;
  logic                                     m_axil_awready_i;
  logic [burst_io_pkg::axil_data_width-1:0] m_axil_wdata_o;
  logic [burst_io_pkg::axil_strb_width-1:0] m_axil_wstrb_o;
  logic                                     m_axil_wvalid_o;
  logic                                     m_axil_wready_i;
  burst_io_pkg::axi_resp_e                  m_axil_bresp_i;
  logic                                     m_axil_bvalid_i;
  logic                                     m_axil_bready_o;
  logic [burst_io_pkg::axil_addr_width-1:0] m_axil_araddr_o;
  burst_io_pkg::axi_prot_e                  m_axil_arprot_o;
  logic                                     m_axil_arvalid_o;
  logic                                     m_axil_arready_i;
  logic [burst_io_pkg::axil_data_width-1:0] m_axil_rdata_i;
  burst_io_pkg::axi_resp_e                  m_axil_rresp_i;
  logic                                     m_axil_rvalid_i;
  logic                                     m_axil_rready_o;

  // every bridge port has a same-named signal here
  burst_to_axil bridge_i (.*);

  axil_scratchpad scratch_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (m_axil_awaddr_o),
    .s_axil_awprot_i  (m_axil_awprot_o),
    .s_axil_awvalid_i (m_axil_awvalid_o),
    .s_axil_awready_o (m_axil_awready_i),
    .s_axil_wdata_i   (m_axil_wdata_o),
    .s_axil_wstrb_i   (m_axil_wstrb_o),
    .s_axil_wvalid_i  (m_axil_wvalid_o),
    .s_axil_wready_o  (m_axil_wready_i),
    .s_axil_bresp_o   (m_axil_bresp_i),
    .s_axil_bvalid_o  (m_axil_bvalid_i),
    .s_axil_bready_i  (m_axil_bready_o),
    .s_axil_araddr_i  (m_axil_araddr_o),
    .s_axil_arprot_i  (m_axil_arprot_o),
    .s_axil_arvalid_i (m_axil_arvalid_o),
    .s_axil_arready_o (m_axil_arready_i),
    .s_axil_rdata_o   (m_axil_rdata_i),
    .s_axil_rresp_o   (m_axil_rresp_i),
    .s_axil_rvalid_o  (m_axil_rvalid_i),
    .s_axil_rready_i  (m_axil_rready_o)
  );

endmodule

`default_nettype wire

/* source/axil_scratchpad.sv */
// axil_scratchpad
// AXI4-Lite subordinate backed by a word array with byte strobes.
// Write address and write data are taken independently and merged once
// both are held; reads are served one at a time from a data register.

`timescale 1ns/1ps
`default_nettype none

module axil_scratchpad (
  input  logic                                        clk_i,
  input  logic                                        reset_i,

  input  logic [burst_io_pkg::axil_addr_width-1:0]    s_axil_awaddr_i,
  input  burst_io_pkg::axi_prot_e                     s_axil_awprot_i,
  input  logic                                        s_axil_awvalid_i,
  output logic                                        s_axil_awready_o,
  input  logic [burst_io_pkg::axil_data_width-1:0]    s_axil_wdata_i,
  input  logic [burst_io_pkg::axil_strb_width-1:0]    s_axil_wstrb_i,
  input  logic                                        s_axil_wvalid_i,
  output logic                                        s_axil_wready_o,
  output burst_io_pkg::axi_resp_e                     s_axil_bresp_o,
  output logic                                        s_axil_bvalid_o,
  input  logic                                        s_axil_bready_i,
  input  logic [burst_io_pkg::axil_addr_width-1:0]    s_axil_araddr_i,
  input  burst_io_pkg::axi_prot_e                     s_axil_arprot_i,
  input  logic                                        s_axil_arvalid_i,
  output logic                                        s_axil_arready_o,
  output logic [burst_io_pkg::axil_data_width-1:0]    s_axil_rdata_o,
  output burst_io_pkg::axi_resp_e                     s_axil_rresp_o,
  output logic                                        s_axil_rvalid_o,
  input  logic                                        s_axil_rready_i
);

  logic [burst_io_pkg::axil_data_width-1:0] mem [burst_io_pkg::scratch_words];

  logic                                       aw_held_r;
  logic                                       w_held_r;
  logic [burst_io_pkg::scratch_idx_width-1:0] wr_idx_r;
  logic [burst_io_pkg::axil_data_width-1:0]   wdata_r;
  logic [burst_io_pkg::axil_strb_width-1:0]   wstrb_r;
  logic                                       bvalid_r;
  logic                                       rvalid_r;
  logic [burst_io_pkg::axil_data_width-1:0]   rdata_r;
  logic                                       wr_apply;

  assign s_axil_awready_o = ~aw_held_r;
  assign s_axil_wready_o  = ~w_held_r;
  assign s_axil_arready_o = ~rvalid_r;
  assign s_axil_bvalid_o  = bvalid_r;
  assign s_axil_rvalid_o  = rvalid_r;
  assign s_axil_rdata_o   = rdata_r;

  // never reports an error
  assign s_axil_bresp_o = burst_io_pkg::e_axi_resp_okay;
  assign s_axil_rresp_o = burst_io_pkg::e_axi_resp_okay;

  // both halves present and no response outstanding
  assign wr_apply = aw_held_r & w_held_r & ~bvalid_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_held_r <= 1'b0;
      w_held_r  <= 1'b0;
      bvalid_r  <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      if (s_axil_awvalid_i & ~aw_held_r) begin
        aw_held_r <= 1'b1;
      end
      if (s_axil_wvalid_i & ~w_held_r) begin
        w_held_r <= 1'b1;
      end
      if (wr_apply) begin
        bvalid_r <= 1'b1;
      end
      // buffers free up once the response is taken
      if (bvalid_r & s_axil_bready_i) begin
        bvalid_r  <= 1'b0;
        aw_held_r <= 1'b0;
        w_held_r  <= 1'b0;
      end
      if (s_axil_arvalid_i & ~rvalid_r) begin
        rvalid_r <= 1'b1;
      end else if (rvalid_r & s_axil_rready_i) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // payload capture, word index from address bits 9 to 2
  always_ff @(posedge clk_i) begin
    if (s_axil_awvalid_i & ~aw_held_r) begin
      wr_idx_r <= s_axil_awaddr_i[2 +: burst_io_pkg::scratch_idx_width];
    end
    if (s_axil_wvalid_i & ~w_held_r) begin
      wdata_r <= s_axil_wdata_i;
      wstrb_r <= s_axil_wstrb_i;
    end
    if (s_axil_arvalid_i & ~rvalid_r) begin
      rdata_r <= mem[s_axil_araddr_i[2 +: burst_io_pkg::scratch_idx_width]];
    end
  end

  // strobed byte merge
  always_ff @(posedge clk_i) begin
    if (wr_apply) begin
      for (int i = 0; i < burst_io_pkg::axil_strb_width; i++) begin
        if (wstrb_r[i]) begin
          mem[wr_idx_r][8*i +: 8] <= wdata_r[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/burst_to_axil.sv */
// burst_to_axil
// Minimal AXI4-Lite manager behind a burst command/response port.
// Holds one command header at a time and walks the AXI address, data and
// response channels for a single-beat read or write of 1, 2 or 4 bytes.

`timescale 1ns/1ps
`default_nettype none

module burst_to_axil (
  input  logic                                        clk_i,
  input  logic                                        reset_i,

  // burst command
  input  logic                                        cmd_header_v_i,
  output logic                                        cmd_header_ready_o,
  input  burst_io_pkg::mem_msg_e                      cmd_type_i,
  input  burst_io_pkg::mem_size_e                     cmd_size_i,
  input  logic [burst_io_pkg::paddr_width-1:0]        cmd_addr_i,
  input  logic                                        cmd_has_data_i,
  input  logic                                        cmd_data_v_i,
  output logic                                        cmd_data_ready_o,
  input  logic [burst_io_pkg::io_data_width-1:0]      cmd_data_i,
  input  logic                                        cmd_last_i,

  // burst response
  output logic                                        resp_header_v_o,
  input  logic                                        resp_header_ready_i,
  output burst_io_pkg::mem_msg_e                      resp_type_o,
  output burst_io_pkg::mem_size_e                     resp_size_o,
  output logic [burst_io_pkg::paddr_width-1:0]        resp_addr_o,
  output logic                                        resp_has_data_o,
  output logic                                        resp_data_v_o,
  input  logic                                        resp_data_ready_i,
  output logic [burst_io_pkg::io_data_width-1:0]      resp_data_o,
  output logic                                        resp_last_o,

  // AXI4-Lite manager
  output logic [burst_io_pkg::axil_addr_width-1:0]    m_axil_awaddr_o,
  output burst_io_pkg::axi_prot_e                     m_axil_awprot_o,
  output logic                                        m_axil_awvalid_o,
  input  logic                                        m_axil_awready_i,
  output logic [burst_io_pkg::axil_data_width-1:0]    m_axil_wdata_o,
  output logic [burst_io_pkg::axil_strb_width-1:0]    m_axil_wstrb_o,
  output logic                                        m_axil_wvalid_o,
  input  logic                                        m_axil_wready_i,
  input  burst_io_pkg::axi_resp_e                     m_axil_bresp_i,
  input  logic                                        m_axil_bvalid_i,
  output logic                                        m_axil_bready_o,
  output logic [burst_io_pkg::axil_addr_width-1:0]    m_axil_araddr_o,
  output burst_io_pkg::axi_prot_e                     m_axil_arprot_o,
  output logic                                        m_axil_arvalid_o,
  input  logic                                        m_axil_arready_i,
  input  logic [burst_io_pkg::axil_data_width-1:0]    m_axil_rdata_i,
  input  burst_io_pkg::axi_resp_e                     m_axil_rresp_i,
  input  logic                                        m_axil_rvalid_i,
  output logic                                        m_axil_rready_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_read_addr,
    e_read_header,
    e_read_data,
    e_write_addr_and_data,
    e_write_addr,
    e_write_data,
    e_write_resp
  } state_e;

  state_e state_r;
  state_e state_n;

  // held command header
  burst_io_pkg::mem_msg_e                  type_r;
  burst_io_pkg::mem_size_e                 size_r;
  logic [burst_io_pkg::paddr_width-1:0]    addr_r;
  logic                                    has_data_r;
  logic [burst_io_pkg::axil_strb_width-1:0] size_mask;

  always_ff @(posedge clk_i) begin
    if (cmd_header_v_i & cmd_header_ready_o) begin
      type_r     <= cmd_type_i;
      size_r     <= cmd_size_i;
      addr_r     <= cmd_addr_i;
      has_data_r <= cmd_has_data_i;
    end
  end

  // response header echoes the command
  assign resp_type_o     = type_r;
  assign resp_size_o     = size_r;
  assign resp_addr_o     = addr_r;
  assign resp_has_data_o = ~has_data_r;
  assign resp_last_o     = 1'b1;

  resp_data_pack resp_pack_i (
    .data_i (m_axil_rdata_i),
    .sel_i  (addr_r[1:0]),
    .size_i (size_r),
    .data_o (resp_data_o)
  );

  always_comb begin
    case (size_r)
      burst_io_pkg::e_size_1: size_mask = 4'b0001;
      burst_io_pkg::e_size_2: size_mask = 4'b0011;
      default:                size_mask = 4'b1111;
    endcase
  end

  // address, prot and data are static for the whole command
  assign m_axil_awaddr_o = addr_r[burst_io_pkg::axil_addr_width-1:0];
  assign m_axil_araddr_o = addr_r[burst_io_pkg::axil_addr_width-1:0];
  assign m_axil_awprot_o = burst_io_pkg::e_axi_prot_dsn;
  assign m_axil_arprot_o = burst_io_pkg::e_axi_prot_dsn;
  assign m_axil_wstrb_o  = size_mask << addr_r[1:0];
  // written bytes are replicated, so the low word already has them in lane
  assign m_axil_wdata_o  = cmd_data_i[burst_io_pkg::axil_data_width-1:0];

  always_comb begin
    state_n            = state_r;
    cmd_header_ready_o = 1'b0;
    cmd_data_ready_o   = 1'b0;
    resp_header_v_o    = 1'b0;
    resp_data_v_o      = 1'b0;
    m_axil_awvalid_o   = 1'b0;
    m_axil_wvalid_o    = 1'b0;
    m_axil_bready_o    = 1'b0;
    m_axil_arvalid_o   = 1'b0;
    m_axil_rready_o    = 1'b0;

    case (state_r)
      e_ready: begin
        cmd_header_ready_o = 1'b1;
        if (cmd_header_v_i) begin
          state_n = cmd_has_data_i ? e_write_addr_and_data : e_read_addr;
        end
      end

      // aw and w offered together, either may be taken first
      e_write_addr_and_data: begin
        m_axil_awvalid_o = 1'b1;
        m_axil_wvalid_o  = cmd_data_v_i;
        cmd_data_ready_o = m_axil_wready_i;
        if (m_axil_awready_i & cmd_data_v_i & m_axil_wready_i) begin
          state_n = e_write_resp;
        end else if (m_axil_awready_i) begin
          state_n = e_write_data;
        end else if (cmd_data_v_i & m_axil_wready_i) begin
          state_n = e_write_addr;
        end
      end

      e_write_addr: begin
        m_axil_awvalid_o = 1'b1;
        if (m_axil_awready_i) begin
          state_n = e_write_resp;
        end
      end

      // data beat may still be late here
      e_write_data: begin
        m_axil_wvalid_o  = cmd_data_v_i;
        cmd_data_ready_o = m_axil_wready_i;
        if (cmd_data_v_i & m_axil_wready_i) begin
          state_n = e_write_resp;
        end
      end

      // b and the response header move in the same cycle
      e_write_resp: begin
        m_axil_bready_o = resp_header_ready_i;
        resp_header_v_o = m_axil_bvalid_i;
        if (m_axil_bvalid_i & resp_header_ready_i) begin
          state_n = e_ready;
        end
      end

      e_read_addr: begin
        m_axil_arvalid_o = 1'b1;
        if (m_axil_arready_i) begin
          state_n = e_read_header;
        end
      end

      e_read_header: begin
        resp_header_v_o = 1'b1;
        if (resp_header_ready_i) begin
          state_n = e_read_data;
        end
      end

      e_read_data: begin
        m_axil_rready_o = resp_data_ready_i;
        resp_data_v_o   = m_axil_rvalid_i;
        if (m_axil_rvalid_i & resp_data_ready_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_ready;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

/* source/resp_data_pack.sv */
// resp_data_pack
// Picks the addressed bytes out of an AXI4-Lite read word and repeats
// them across the whole burst response data word.

`timescale 1ns/1ps
`default_nettype none

module resp_data_pack (
  input  logic [burst_io_pkg::axil_data_width-1:0] data_i,
  input  logic [1:0]                               sel_i,
  input  burst_io_pkg::mem_size_e                  size_i,
  output logic [burst_io_pkg::io_data_width-1:0]   data_o
);

  logic [burst_io_pkg::axil_data_width-1:0] shifted;

  // byte offset to bit shift
  assign shifted = data_i >> {sel_i, 3'b000};

  always_comb begin
    case (size_i)
      burst_io_pkg::e_size_1: begin
        data_o = {(burst_io_pkg::io_data_width / 8){shifted[7:0]}};
      end
      burst_io_pkg::e_size_2: begin
        data_o = {(burst_io_pkg::io_data_width / 16){shifted[15:0]}};
      end
      default: begin
        // full word, also covers the unsupported 8-byte case
        data_o = {(burst_io_pkg::io_data_width / burst_io_pkg::axil_data_width){shifted}};
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/burst_io_pkg.sv */
// burst_io_pkg
// Shared message encodings, AXI4-Lite codes and widths for the burst I/O
// bridge and its scratchpad device.

`default_nettype none

package burst_io_pkg;

  // burst message types
  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_e;

  // log2 of the byte count, size_8 is not handled by the bridge
  typedef enum logic [2:0] {
    e_size_1 = 3'b000,
    e_size_2 = 3'b001,
    e_size_4 = 3'b010,
    e_size_8 = 3'b011
  } mem_size_e;

  typedef enum logic [1:0] {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_e;

  // bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef enum logic [2:0] {
    e_axi_prot_dsn = 3'b000,
    e_axi_prot_dsp = 3'b001,
    e_axi_prot_dnn = 3'b010,
    e_axi_prot_isn = 3'b100
  } axi_prot_e;

  localparam int paddr_width     = 32;
  localparam int io_data_width   = 64;
  localparam int axil_data_width = 32;
  localparam int axil_strb_width = axil_data_width / 8;
  localparam int axil_addr_width = 32;

  // scratchpad depth in 32-bit words
  localparam int scratch_words     = 256;
  localparam int scratch_idx_width = $clog2(scratch_words);

endpackage

`default_nettype wire
